//--- Makefile
# Verilator build and run for the graphics controller testbench

VERILATOR ?= verilator
TOP       ?= gfx_tb
FILELIST  ?= sim.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, fail if the log reports failure"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Result: FAILED" $(LOG); then exit 1; fi; \
	if [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/gfx_tb.sv
`timescale 1ns/10ps
`default_nettype none

module gfx_tb
    import gfx_pkg::*;
;
    localparam int OP_WR = 0;
    localparam int OP_RD = 1;
    localparam int OP_WFRAME = 2;
    localparam int OP_CHKFRAME = 3;
    localparam int OP_SCROLL_MID = 4;

    logic vga_clk = 1'b0;
    logic rst;
    logic [7:0] awaddr, araddr;
    logic awvalid, wvalid, bready, arvalid, rready;
    logic [31:0] wdata;
    logic [3:0] wstrb;
    wire awready, wready, bvalid, arready, rvalid;
    wire [1:0] bresp, rresp;
    wire [31:0] rdata;
    wire hsync_o, vsync_o, de_o;
    wire [11:0] rgb_o;

    int op_q[$];
    int test_q[$];
    logic [7:0] addr_q[$];
    logic [31:0] data_q[$];
    logic [1:0] resp_q[$];
    bit chk_q[$];

    logic [31:0] fb_model [32];
    logic [4:0] model_scroll;
    logic [4:0] frame_s;
    int out_idx;
    int checked;
    bit check_en;
    int errors;
    int tests_failed;
    int tests_run;
    int cycles;
    int limit;

    gfx_top i_gfx_top (
        .vga_clk(vga_clk), .rst(rst),
        .s_axil_awaddr_i(awaddr), .s_axil_awvalid_i(awvalid), .s_axil_awready_o(awready),
        .s_axil_wdata_i(wdata), .s_axil_wstrb_i(wstrb), .s_axil_wvalid_i(wvalid),
        .s_axil_wready_o(wready), .s_axil_bresp_o(bresp), .s_axil_bvalid_o(bvalid),
        .s_axil_bready_i(bready), .s_axil_araddr_i(araddr), .s_axil_arvalid_i(arvalid),
        .s_axil_arready_o(arready), .s_axil_rdata_o(rdata), .s_axil_rresp_o(rresp),
        .s_axil_rvalid_o(rvalid), .s_axil_rready_i(rready),
        .hsync_o(hsync_o), .vsync_o(vsync_o), .de_o(de_o), .rgb_o(rgb_o)
    );

    initial begin
        vga_clk = 1'b0;
        forever #20 vga_clk = ~vga_clk;
    end

    task automatic err(input string msg);
        errors++;
        $display("ERR %0t: %s", $time, msg);
    endtask

    function automatic logic [31:0] pattern(input int idx, input int salt);
        logic [31:0] v;
        v = 32'(idx + 1) * 32'h9e37_79b1;
        return v ^ 32'(salt);
    endfunction

    // red = c, green = ~c, blue = c with halves swapped
    function automatic logic [11:0] pixel_color(input logic [31:0] word, input int n);
        logic [3:0] c;
        c = word[n*4 +: 4];
        return {c, ~c, c[1:0], c[3:2]};
    endfunction

    task automatic add_entry(input int op, input int test, input logic [7:0] addr,
                             input logic [31:0] data, input logic [1:0] resp, input bit chk);
        op_q.push_back(op);
        test_q.push_back(test);
        addr_q.push_back(addr);
        data_q.push_back(data);
        resp_q.push_back(resp);
        chk_q.push_back(chk);
    endtask

    always @(posedge vga_clk) begin
        cycles++;
        if (cycles >= limit) begin
            $display("run timed out after %0d cycles", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    // pixel monitor samples the registered outputs on the falling edge
    always @(negedge vga_clk) begin
        if (!vsync_o) begin
            out_idx = 0;
        end else if (de_o) begin
            if (out_idx == 0) begin
                frame_s = model_scroll;
            end
            if (check_en && out_idx < 256) begin
                if (rgb_o !== pixel_color(fb_model[((out_idx / 8) + int'(frame_s)) % 32],
                                          out_idx % 8)) begin
                    err($sformatf("pixel %0d rgb %h, scroll %0d", out_idx, rgb_o, frame_s));
                end
                checked++;
            end
            out_idx++;
        end else if (check_en && rgb_o !== 12'h000) begin
            err("rgb not blank outside display enable");
        end
    end

    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int d;
        @(posedge vga_clk);
        #2;
        awaddr = addr;
        wdata = data;
        awvalid = 1'b1;
        wvalid = 1'b1;
        @(negedge vga_clk);
        while (!(awready && wready)) @(negedge vga_clk);
        @(posedge vga_clk);
        #2;
        awvalid = 1'b0;
        wvalid = 1'b0;
        @(negedge vga_clk);
        while (!bvalid) @(negedge vga_clk);
        resp = bresp;
        d = int'($urandom % 8);
        repeat (d) begin
            @(negedge vga_clk);
            if (!bvalid || bresp !== resp) err("write response changed before BREADY");
        end
        @(posedge vga_clk);
        #2;
        bready = 1'b1;
        @(posedge vga_clk);
        #2;
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int d;
        @(posedge vga_clk);
        #2;
        araddr = addr;
        arvalid = 1'b1;
        @(negedge vga_clk);
        while (!arready) @(negedge vga_clk);
        @(posedge vga_clk);
        #2;
        arvalid = 1'b0;
        @(negedge vga_clk);
        while (!rvalid) @(negedge vga_clk);
        data = rdata;
        resp = rresp;
        d = int'($urandom % 8);
        repeat (d) begin
            @(negedge vga_clk);
            if (!rvalid || rdata !== data || rresp !== resp) begin
                err("read response changed before RREADY");
            end
        end
        @(posedge vga_clk);
        #2;
        rready = 1'b1;
        @(posedge vga_clk);
        #2;
        rready = 1'b0;
    endtask

    // returns on the first falling-edge sample with vsync low
    task automatic wait_frame_start();
        @(negedge vga_clk);
        while (!vsync_o) @(negedge vga_clk);
        while (vsync_o) @(negedge vga_clk);
    endtask

    task automatic check_frame(input bit scroll_write, input logic [31:0] value);
        logic [1:0] resp;
        wait_frame_start();
        out_idx = 0;
        checked = 0;
        check_en = 1'b1;
        if (scroll_write) begin
            while (out_idx < 64) @(negedge vga_clk);
            axi_write(ADDR_SCROLL, value, resp);
            if (resp !== RESP_OKAY) err("scroll write not OKAY");
            model_scroll = value[4:0];
        end
        while (out_idx < 256) @(negedge vga_clk);
        @(negedge vga_clk);
        check_en = 1'b0;
        if (checked != 256) err($sformatf("checked %0d pixels in frame", checked));
    endtask

    task automatic measure_frame();
        int hs_low, vs_low, de_cnt, run;
        hs_low = 0;
        vs_low = 0;
        de_cnt = 0;
        run = 0;
        wait_frame_start();
        repeat (480) begin
            if (!hsync_o) hs_low++;
            if (!vsync_o) vs_low++;
            if (de_o) begin
                de_cnt++;
                run++;
            end else if (run != 0) begin
                if (run != 32) err($sformatf("display enable run of %0d", run));
                run = 0;
            end
            @(negedge vga_clk);
        end
        if (hs_low != 48) err($sformatf("hsync low %0d cycles per frame", hs_low));
        if (vs_low != 80) err($sformatf("vsync low %0d cycles per frame", vs_low));
        if (de_cnt != 256) err($sformatf("display enable %0d cycles per frame", de_cnt));
        if (vsync_o) err("frame period is not 480 cycles");
    endtask

    task automatic check_reset_outputs();
        if (awready || wready || bvalid || arready || rvalid) err("handshake high in reset");
        if (hsync_o !== 1'b1 || vsync_o !== 1'b1) err("sync not idle in reset");
        if (de_o !== 1'b0 || rgb_o !== 12'h000) err("video not blank in reset");
    endtask

    task automatic report_test(input int n, input int base);
        string name;
        case (n)
            1: name = "reset state";
            2: name = "raster timing";
            3: name = "register access";
            4: name = "pixel output";
            5: name = "scroll";
            default: name = "back-pressure";
        endcase
        tests_run++;
        if (errors != base) tests_failed++;
        $display("test %0d %s: %0d errors", n, name, errors - base);
    endtask

    initial begin
        logic [31:0] rd;
        logic [1:0] resp;
        int base;
        void'($urandom(32'h0df1_0cf1));
        rst = 1'b1;
        {awaddr, araddr, wdata} = '0;
        {awvalid, wvalid, bready, arvalid, rready} = '0;
        wstrb = 4'hf;
        model_scroll = '0;
        frame_s = '0;
        check_en = 1'b0;
        for (int i = 0; i < 32; i++) fb_model[i] = '0;

        for (int i = 0; i < 32; i++) add_entry(OP_WR, 3, 8'(i * 4), pattern(i, 0), RESP_OKAY, 1);
        for (int i = 0; i < 32; i++) add_entry(OP_RD, 3, 8'(i * 4), pattern(i, 0), RESP_OKAY, 1);
        add_entry(OP_WR, 3, ADDR_SCROLL, 32'h0000_0003, RESP_OKAY, 1);
        add_entry(OP_RD, 3, ADDR_SCROLL, 32'h0000_0003, RESP_OKAY, 1);
        add_entry(OP_WR, 3, ADDR_SCROLL, 32'h0000_0000, RESP_OKAY, 1);
        add_entry(OP_WR, 3, ADDR_SCANPOS, 32'hffff_ffff, RESP_SLVERR, 1);
        add_entry(OP_RD, 3, ADDR_SCANPOS, 32'h0, RESP_OKAY, 0);
        add_entry(OP_RD, 3, ADDR_SCROLL, 32'h0, RESP_OKAY, 1);
        add_entry(OP_RD, 3, 8'h04, pattern(1, 0), RESP_OKAY, 1);
        add_entry(OP_WR, 3, 8'h88, 32'h1234_5678, RESP_SLVERR, 1);
        add_entry(OP_RD, 3, 8'h88, 32'h0, RESP_SLVERR, 1);
        add_entry(OP_RD, 3, 8'hfc, 32'h0, RESP_SLVERR, 1);
        add_entry(OP_WFRAME, 4, 8'h00, 32'h0, RESP_OKAY, 0);
        add_entry(OP_CHKFRAME, 4, 8'h00, 32'h0, RESP_OKAY, 0);
        add_entry(OP_SCROLL_MID, 5, ADDR_SCROLL, 32'h0000_0005, RESP_OKAY, 0);
        add_entry(OP_CHKFRAME, 5, 8'h00, 32'h0, RESP_OKAY, 0);
        for (int i = 8; i < 16; i++) add_entry(OP_WR, 6, 8'(i * 4), pattern(i, 7), RESP_OKAY, 1);
        for (int i = 8; i < 16; i++) add_entry(OP_RD, 6, 8'(i * 4), pattern(i, 7), RESP_OKAY, 1);
        limit = 12 * 480 + 200 * op_q.size();

        base = errors;
        repeat (16) begin
            @(negedge vga_clk);
            check_reset_outputs();
        end
        @(posedge vga_clk);
        #2;
        rst = 1'b0;
        @(negedge vga_clk);
        check_reset_outputs();
        report_test(1, base);

        base = errors;
        measure_frame();
        report_test(2, base);

        base = errors;
        for (int i = 0; i < op_q.size(); i++) begin
            case (op_q[i])
                OP_WR: begin
                    axi_write(addr_q[i], data_q[i], resp);
                    if (resp !== resp_q[i]) err($sformatf("write %h resp %b", addr_q[i], resp));
                    if (resp_q[i] == RESP_OKAY && addr_q[i] < 8'h80) begin
                        fb_model[addr_q[i][6:2]] = data_q[i];
                    end else if (resp_q[i] == RESP_OKAY) begin
                        model_scroll = data_q[i][4:0];
                    end
                end
                OP_RD: begin
                    axi_read(addr_q[i], rd, resp);
                    if (resp !== resp_q[i]) err($sformatf("read %h resp %b", addr_q[i], resp));
                    if (chk_q[i] && rd !== data_q[i]) begin
                        err($sformatf("read %h got %h want %h", addr_q[i], rd, data_q[i]));
                    end
                end
                OP_WFRAME: wait_frame_start();
                OP_CHKFRAME: check_frame(1'b0, 32'h0);
                default: check_frame(1'b1, data_q[i]);
            endcase
            if (i == op_q.size() - 1 || test_q[i + 1] != test_q[i]) begin
                report_test(test_q[i], base);
                base = errors;
            end
        end

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
src/gfx_pkg.sv
src/gfx_framebuffer.sv
src/gfx_raster_timing.sv
src/gfx_pixel_fetch.sv
src/gfx_axil_slave.sv
src/gfx_top.sv
dv/gfx_tb.sv

//--- src/gfx_axil_slave.sv
`timescale 1ns/10ps
`default_nettype none

module gfx_axil_slave
    import gfx_pkg::*;
(
    input  wire                   vga_clk,
    input  wire                   rst,
    input  wire  [AXI_ADDR_W-1:0] s_axil_awaddr_i,
    input  wire                   s_axil_awvalid_i,
    output logic                  s_axil_awready_o,
    input  wire  [DATA_W-1:0]     s_axil_wdata_i,
    input  wire  [STRB_W-1:0]     s_axil_wstrb_i,
    input  wire                   s_axil_wvalid_i,
    output logic                  s_axil_wready_o,
    output logic [1:0]            s_axil_bresp_o,
    output logic                  s_axil_bvalid_o,
    input  wire                   s_axil_bready_i,
    input  wire  [AXI_ADDR_W-1:0] s_axil_araddr_i,
    input  wire                   s_axil_arvalid_i,
    output logic                  s_axil_arready_o,
    output logic [DATA_W-1:0]     s_axil_rdata_o,
    output logic [1:0]            s_axil_rresp_o,
    output logic                  s_axil_rvalid_o,
    input  wire                   s_axil_rready_i,
    output logic                  fb_we_o,
    output logic [FB_ADDR_W-1:0]  fb_addr_o,
    output logic [DATA_W-1:0]     fb_wdata_o,
    input  wire  [DATA_W-1:0]     fb_rdata_i,
    output logic [FB_ADDR_W-1:0]  scroll_words_o,
    input  wire  [DATA_W-1:0]     scan_pos_i
);

    logic                 aw_go;
    logic                 ar_go;
    logic                 wr_fire;
    logic                 rd_fire;
    logic                 wr_fb_hit;
    logic                 wr_scroll_hit;
    logic                 rd_s1_valid;
    logic [1:0]           rd_s1_sel;
    logic [FB_ADDR_W-1:0] scroll_q;

    function automatic logic is_fb(input logic [AXI_ADDR_W-1:0] addr);
        logic [AXI_ADDR_W-1:0] offset;
        offset = addr - ADDR_FB_BASE;
        return offset < AXI_ADDR_W'(FB_WORDS * 4);
    endfunction

    function automatic logic [FB_ADDR_W-1:0] fb_word(input logic [AXI_ADDR_W-1:0] addr);
        logic [AXI_ADDR_W-1:0] offset;
        offset = addr - ADDR_FB_BASE;
        return offset[FB_ADDR_W+1:2];
    endfunction

    function automatic logic [1:0] rd_decode(input logic [AXI_ADDR_W-1:0] addr);
        logic [1:0] sel;
        if (is_fb(addr)) begin
            sel = RD_SEL_FB;
        end else if (addr[AXI_ADDR_W-1:2] == ADDR_SCROLL[AXI_ADDR_W-1:2]) begin
            sel = RD_SEL_SCROLL;
        end else if (addr[AXI_ADDR_W-1:2] == ADDR_SCANPOS[AXI_ADDR_W-1:2]) begin
            sel = RD_SEL_SCAN;
        end else begin
            sel = RD_SEL_NONE;
        end
        return sel;
    endfunction

    // a write acceptance always wins the shared port A
    assign aw_go = s_axil_awvalid_i && s_axil_wvalid_i && !s_axil_bvalid_o && !s_axil_awready_o;
    assign ar_go = s_axil_arvalid_i && !s_axil_arready_o && !rd_s1_valid &&
                   !s_axil_rvalid_o && !aw_go;

    assign wr_fire = s_axil_awready_o && s_axil_awvalid_i && s_axil_wvalid_i;
    assign rd_fire = s_axil_arready_o && s_axil_arvalid_i;

    assign wr_fb_hit     = is_fb(s_axil_awaddr_i);
    assign wr_scroll_hit = s_axil_awaddr_i[AXI_ADDR_W-1:2] == ADDR_SCROLL[AXI_ADDR_W-1:2];

    assign fb_we_o    = wr_fire && wr_fb_hit;
    assign fb_addr_o  = wr_fire ? fb_word(s_axil_awaddr_i) : fb_word(s_axil_araddr_i);
    assign fb_wdata_o = s_axil_wdata_i;

    assign scroll_words_o = scroll_q;

    always_ff @(posedge vga_clk or posedge rst) begin
        if (rst) begin
            s_axil_awready_o <= 1'b0;
            s_axil_wready_o  <= 1'b0;
            s_axil_bvalid_o  <= 1'b0;
            s_axil_arready_o <= 1'b0;
            s_axil_rvalid_o  <= 1'b0;
            rd_s1_valid      <= 1'b0;
            scroll_q         <= '0;
        end else begin
            s_axil_awready_o <= aw_go;
            s_axil_wready_o  <= aw_go;
            if (wr_fire) begin
                s_axil_bvalid_o <= 1'b1;
                if (wr_scroll_hit) begin
                    scroll_q <= s_axil_wdata_i[FB_ADDR_W-1:0];
                end
            end else if (s_axil_bready_i) begin
                s_axil_bvalid_o <= 1'b0;
            end

            // stage 1 waits for the RAM, stage 2 is the R channel
            s_axil_arready_o <= ar_go;
            rd_s1_valid      <= rd_fire;
            if (rd_s1_valid) begin
                s_axil_rvalid_o <= 1'b1;
            end else if (s_axil_rready_i) begin
                s_axil_rvalid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge vga_clk) begin
        if (wr_fire) begin
            s_axil_bresp_o <= (wr_fb_hit || wr_scroll_hit) ? RESP_OKAY : RESP_SLVERR;
        end
        if (rd_fire) begin
            rd_s1_sel <= rd_decode(s_axil_araddr_i);
        end
        if (rd_s1_valid) begin
            s_axil_rresp_o <= (rd_s1_sel == RD_SEL_NONE) ? RESP_SLVERR : RESP_OKAY;
            case (rd_s1_sel)
                RD_SEL_FB:     s_axil_rdata_o <= fb_rdata_i;
                RD_SEL_SCROLL: s_axil_rdata_o <= DATA_W'(scroll_q);
                RD_SEL_SCAN:   s_axil_rdata_o <= scan_pos_i;
                default:       s_axil_rdata_o <= '0;
            endcase
        end
    end

    bvalid_hold: assert property (@(posedge vga_clk) disable iff (rst)
        s_axil_bvalid_o && !s_axil_bready_i |=> s_axil_bvalid_o && $stable(s_axil_bresp_o))
        else $error("BVALID dropped before BREADY");

    // byte lanes are not supported, only full words
    full_word_write: assert property (@(posedge vga_clk) disable iff (rst)
        wr_fire |-> s_axil_wstrb_i == '1)
        else $error("partial write strobe seen");

endmodule

`default_nettype wire

//--- src/gfx_framebuffer.sv
`timescale 1ns/10ps
`default_nettype none

module gfx_framebuffer
    import gfx_pkg::*;
(
    input  wire                  vga_clk,
    input  wire                  a_we_i,
    input  wire  [FB_ADDR_W-1:0] a_addr_i,
    input  wire  [DATA_W-1:0]    a_wdata_i,
    output logic [DATA_W-1:0]    a_rdata_o,
    input  wire  [FB_ADDR_W-1:0] b_addr_i,
    output logic [DATA_W-1:0]    b_rdata_o
);

    logic [DATA_W-1:0] mem [FB_WORDS];

    // bus side port returns old data on a same-address write
    always_ff @(posedge vga_clk) begin
        if (a_we_i) begin
            mem[a_addr_i] <= a_wdata_i;
        end
        a_rdata_o <= mem[a_addr_i];
    end

    // scan-out port is read only
    always_ff @(posedge vga_clk) begin
        b_rdata_o <= mem[b_addr_i];
    end

endmodule

`default_nettype wire

//--- src/gfx_pixel_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module gfx_pixel_fetch
    import gfx_pkg::*;
(
    input  wire                  vga_clk,
    input  wire                  rst,
    input  wire                  de_i,
    input  wire                  hsync_i,
    input  wire                  vsync_i,
    input  wire  [PIX_IDX_W-1:0] pix_index_i,
    input  wire                  frame_start_i,
    input  wire  [FB_ADDR_W-1:0] scroll_words_i,
    output logic [FB_ADDR_W-1:0] rd_addr_o,
    input  wire  [DATA_W-1:0]    rd_data_i,
    output logic                 hsync_o,
    output logic                 vsync_o,
    output logic                 de_o,
    output logic [RGB_W-1:0]     rgb_o
);

    logic [NIB_SEL_W-1:0] nib_sel;
    logic [FB_ADDR_W-1:0] word_idx;
    logic                 fetch_slot;
    logic                 latch_slot;
    logic                 last_fetch;
    logic [FB_ADDR_W-1:0] fetch_scroll;
    logic [FB_ADDR_W-1:0] scroll_pend;
    logic [FB_ADDR_W-1:0] scroll_q;
    logic [DATA_W-1:0]    cur_word;
    logic [PIX_BITS-1:0]  nibble;
    logic [RGB_W-1:0]     color;

    assign nib_sel  = pix_index_i[NIB_SEL_W-1:0];
    assign word_idx = pix_index_i[PIX_IDX_W-1:NIB_SEL_W];

    // address goes out two pixels before the word boundary, data comes back one later
    assign fetch_slot = de_i && (nib_sel == NIB_SEL_W'(PIX_PER_WORD - 2));
    assign latch_slot = de_i && (nib_sel == NIB_SEL_W'(PIX_PER_WORD - 1));

    // the final fetch of a frame is word 0 of the next frame
    assign last_fetch   = fetch_slot && (pix_index_i == PIX_IDX_W'(FRAME_PIXELS - 2));
    assign fetch_scroll = last_fetch ? scroll_words_i : scroll_q;

    // word index wraps mod FB_WORDS by width
    assign rd_addr_o = word_idx + FB_ADDR_W'(1) + fetch_scroll;

    always_ff @(posedge vga_clk or posedge rst) begin
        if (rst) begin
            scroll_pend <= '0;
            scroll_q    <= '0;
            cur_word    <= '0;
        end else begin
            if (last_fetch) begin
                scroll_pend <= scroll_words_i;
            end
            // same value the first word was fetched with
            if (frame_start_i) begin
                scroll_q <= scroll_pend;
            end
            if (latch_slot) begin
                cur_word <= rd_data_i;
            end
        end
    end

    // little-endian nibble order within the word
    assign nibble = cur_word[nib_sel * PIX_BITS +: PIX_BITS];

    // red = c, green = ~c, blue = c with halves swapped
    assign color = {nibble, ~nibble,
                    nibble[PIX_BITS/2-1:0], nibble[PIX_BITS-1:PIX_BITS/2]};

    always_ff @(posedge vga_clk or posedge rst) begin
        if (rst) begin
            hsync_o <= 1'b1;
            vsync_o <= 1'b1;
            de_o    <= 1'b0;
            rgb_o   <= '0;
        end else begin
            hsync_o <= hsync_i;
            vsync_o <= vsync_i;
            de_o    <= de_i;
            rgb_o   <= de_i ? color : '0;
        end
    end

    frame_start_at_origin: assert property (@(posedge vga_clk) disable iff (rst)
        frame_start_i |-> de_i && (pix_index_i == '0))
        else $error("frame start away from first visible pixel");

endmodule

`default_nettype wire

//--- src/gfx_pkg.sv
`default_nettype none

package gfx_pkg;

    // horizontal line runs sync, back porch, visible, front porch
    localparam int H_VISIBLE  = 32;
    localparam int H_FRONT    = 2;
    localparam int H_SYNC     = 4;
    localparam int H_BACK     = 2;
    localparam int H_TOTAL    = H_SYNC + H_BACK + H_VISIBLE + H_FRONT;
    localparam int H_DE_START = H_SYNC + H_BACK;

    // vertical frame follows the same order in lines
    localparam int V_VISIBLE  = 8;
    localparam int V_FRONT    = 1;
    localparam int V_SYNC     = 2;
    localparam int V_BACK     = 1;
    localparam int V_TOTAL    = V_SYNC + V_BACK + V_VISIBLE + V_FRONT;
    localparam int V_DE_START = V_SYNC + V_BACK;

    // counter and visible coordinate widths
    localparam int X_W        = 6;
    localparam int Y_W        = 4;
    localparam int VIS_X_W    = 5;
    localparam int VIS_Y_W    = 3;
    localparam int SCAN_Y_LSB = 16;

    localparam int FRAME_PIXELS = H_VISIBLE * V_VISIBLE;
    localparam int PIX_IDX_W    = VIS_X_W + VIS_Y_W;
    localparam int PIX_BITS     = 4;
    localparam int DATA_W       = 32;
    localparam int PIX_PER_WORD = DATA_W / PIX_BITS;
    localparam int NIB_SEL_W    = 3;
    localparam int FB_WORDS     = FRAME_PIXELS / PIX_PER_WORD;
    localparam int FB_ADDR_W    = 5;
    localparam int RGB_W        = 3 * PIX_BITS;

    localparam int AXI_ADDR_W = 8;
    localparam int STRB_W     = DATA_W / 8;

    // byte address map
    localparam logic [AXI_ADDR_W-1:0] ADDR_FB_BASE = 8'h00;
    localparam logic [AXI_ADDR_W-1:0] ADDR_SCROLL  = 8'h80;
    localparam logic [AXI_ADDR_W-1:0] ADDR_SCANPOS = 8'h84;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // read data source
    localparam logic [1:0] RD_SEL_FB     = 2'd0;
    localparam logic [1:0] RD_SEL_SCROLL = 2'd1;
    localparam logic [1:0] RD_SEL_SCAN   = 2'd2;
    localparam logic [1:0] RD_SEL_NONE   = 2'd3;

endpackage

`default_nettype wire

//--- src/gfx_raster_timing.sv
`timescale 1ns/10ps
`default_nettype none

module gfx_raster_timing
    import gfx_pkg::*;
(
    input  wire                  vga_clk,
    input  wire                  rst,
    output logic                 hsync_o,
    output logic                 vsync_o,
    output logic                 de_o,
    output logic [PIX_IDX_W-1:0] pix_index_o,
    output logic                 frame_start_o,
    output logic [DATA_W-1:0]    scan_pos_o
);

    logic [X_W-1:0]     x_q;
    logic [Y_W-1:0]     y_q;
    logic               h_act;
    logic               v_act;
    logic [VIS_X_W-1:0] vis_x;
    logic [VIS_Y_W-1:0] vis_y;

    always_ff @(posedge vga_clk or posedge rst) begin
        if (rst) begin
            x_q <= '0;
            y_q <= '0;
        end else begin
            if (x_q == X_W'(H_TOTAL - 1)) begin
                x_q <= '0;
                if (y_q == Y_W'(V_TOTAL - 1)) begin
                    y_q <= '0;
                end else begin
                    y_q <= y_q + Y_W'(1);
                end
            end else begin
                x_q <= x_q + X_W'(1);
            end
        end
    end

    // sync pulses are active low at the start of line and frame
    assign hsync_o = !(x_q < X_W'(H_SYNC));
    assign vsync_o = !(y_q < Y_W'(V_SYNC));

    assign h_act = (x_q >= X_W'(H_DE_START)) && (x_q < X_W'(H_DE_START + H_VISIBLE));
    assign v_act = (y_q >= Y_W'(V_DE_START)) && (y_q < Y_W'(V_DE_START + V_VISIBLE));
    assign de_o  = h_act && v_act;

    assign vis_x = VIS_X_W'(x_q - X_W'(H_DE_START));
    assign vis_y = VIS_Y_W'(y_q - Y_W'(V_DE_START));

    // line length is a power of two, so the index is just y:x
    assign pix_index_o   = de_o ? {vis_y, vis_x} : '0;
    assign frame_start_o = de_o && (vis_x == '0) && (vis_y == '0);

    assign scan_pos_o = {{(DATA_W - SCAN_Y_LSB - Y_W){1'b0}}, y_q,
                         {(SCAN_Y_LSB - X_W){1'b0}}, x_q};

    de_after_hsync: assert property (@(posedge vga_clk) disable iff (rst)
        $rose(de_o) |-> hsync_o)
        else $error("display enable rose inside hsync pulse");

endmodule

`default_nettype wire

//--- src/gfx_top.sv
`timescale 1ns/10ps
`default_nettype none

module gfx_top
    import gfx_pkg::*;
(
    input  wire                   vga_clk,
    input  wire                   rst,
    input  wire  [AXI_ADDR_W-1:0] s_axil_awaddr_i,
    input  wire                   s_axil_awvalid_i,
    output logic                  s_axil_awready_o,
    input  wire  [DATA_W-1:0]     s_axil_wdata_i,
    input  wire  [STRB_W-1:0]     s_axil_wstrb_i,
    input  wire                   s_axil_wvalid_i,
    output logic                  s_axil_wready_o,
    output logic [1:0]            s_axil_bresp_o,
    output logic                  s_axil_bvalid_o,
    input  wire                   s_axil_bready_i,
    input  wire  [AXI_ADDR_W-1:0] s_axil_araddr_i,
    input  wire                   s_axil_arvalid_i,
    output logic                  s_axil_arready_o,
    output logic [DATA_W-1:0]     s_axil_rdata_o,
    output logic [1:0]            s_axil_rresp_o,
    output logic                  s_axil_rvalid_o,
    input  wire                   s_axil_rready_i,
    output logic                  hsync_o,
    output logic                  vsync_o,
    output logic                  de_o,
    output logic [RGB_W-1:0]      rgb_o
);

    logic                 fb_we;
    logic [FB_ADDR_W-1:0] fb_addr;
    logic [DATA_W-1:0]    fb_wdata;
    logic [DATA_W-1:0]    fb_rdata;
    logic [FB_ADDR_W-1:0] scroll_words;
    logic [DATA_W-1:0]    scan_pos;
    logic                 de;
    logic                 hsync;
    logic                 vsync;
    logic [PIX_IDX_W-1:0] pix_index;
    logic                 frame_start;
    logic [FB_ADDR_W-1:0] scan_addr;
    logic [DATA_W-1:0]    scan_data;

    gfx_axil_slave i_gfx_axil_slave (
        .vga_clk          (vga_clk),
        .rst              (rst),
        .s_axil_awaddr_i  (s_axil_awaddr_i),
        .s_axil_awvalid_i (s_axil_awvalid_i),
        .s_axil_awready_o (s_axil_awready_o),
        .s_axil_wdata_i   (s_axil_wdata_i),
        .s_axil_wstrb_i   (s_axil_wstrb_i),
        .s_axil_wvalid_i  (s_axil_wvalid_i),
        .s_axil_wready_o  (s_axil_wready_o),
        .s_axil_bresp_o   (s_axil_bresp_o),
        .s_axil_bvalid_o  (s_axil_bvalid_o),
        .s_axil_bready_i  (s_axil_bready_i),
        .s_axil_araddr_i  (s_axil_araddr_i),
        .s_axil_arvalid_i (s_axil_arvalid_i),
        .s_axil_arready_o (s_axil_arready_o),
        .s_axil_rdata_o   (s_axil_rdata_o),
        .s_axil_rresp_o   (s_axil_rresp_o),
        .s_axil_rvalid_o  (s_axil_rvalid_o),
        .s_axil_rready_i  (s_axil_rready_i),
        .fb_we_o          (fb_we),
        .fb_addr_o        (fb_addr),
        .fb_wdata_o       (fb_wdata),
        .fb_rdata_i       (fb_rdata),
        .scroll_words_o   (scroll_words),
        .scan_pos_i       (scan_pos)
    );

    gfx_framebuffer i_gfx_framebuffer (
        .vga_clk   (vga_clk),
        .a_we_i    (fb_we),
        .a_addr_i  (fb_addr),
        .a_wdata_i (fb_wdata),
        .a_rdata_o (fb_rdata),
        .b_addr_i  (scan_addr),
        .b_rdata_o (scan_data)
    );

    gfx_raster_timing i_gfx_raster_timing (
        .vga_clk       (vga_clk),
        .rst           (rst),
        .hsync_o       (hsync),
        .vsync_o       (vsync),
        .de_o          (de),
        .pix_index_o   (pix_index),
        .frame_start_o (frame_start),
        .scan_pos_o    (scan_pos)
    );

    gfx_pixel_fetch i_gfx_pixel_fetch (
        .vga_clk        (vga_clk),
        .rst            (rst),
        .de_i           (de),
        .hsync_i        (hsync),
        .vsync_i        (vsync),
        .pix_index_i    (pix_index),
        .frame_start_i  (frame_start),
        .scroll_words_i (scroll_words),
        .rd_addr_o      (scan_addr),
        .rd_data_i      (scan_data),
        .hsync_o        (hsync_o),
        .vsync_o        (vsync_o),
        .de_o           (de_o),
        .rgb_o          (rgb_o)
    );

endmodule

`default_nettype wire
